// ==== design/uartPkg.sv ====
package uartPkg;

	//////////////////////////////
	// bus and register map
	//////////////////////////////

	// width of the APB data path and of every register
	localparam int DATA_W = 16;

	// register offsets as seen on the 2-bit APB address
	typedef enum logic [1:0] {
		statusReg = 2'd0,
		dataReg   = 2'd1,
		rxDivReg  = 2'd2,
		txDivReg  = 2'd3
	} regAddrE;

	// bit positions inside the status register
	localparam int STAT_RX_AVAIL  = 0;
	localparam int STAT_TX_ACTIVE = 1;
	localparam int STAT_TX_DONE   = 2;

	// both dividers come out of reset at this value
	localparam logic [15:0] DIV_RESET = 16'd217;

	//////////////////////////////
	// serial state machines
	//////////////////////////////

	// receiver walks through one frame, start bit is re-checked at half period
	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxStateE;

	// transmitter sends start, eight data bits and stop
	typedef enum logic [1:0] {
		txIdle,
		txStart,
		txData,
		txStop
	} txStateE;

endpackage

// ==== design/uartRx.sv ====
`timescale 1ns/1ps

module uartRx #(
	parameter int DIV_W = 16
) (
	input  logic             CLK,
	input  logic             RESET,
	input  logic             i_rxd,
	input  logic [DIV_W-1:0] i_div,
	output logic             o_valid,
	output logic [7:0]       o_byte
);
	import uartPkg::*;

	// two-flop synchronizer on the asynchronous serial line
	logic rxMeta;
	logic rxSync;

	rxStateE          state;
	logic [DIV_W-1:0] bitCnt;
	logic [2:0]       bitIdx;
	logic [7:0]       shiftReg;
	logic             bitEnd;
	logic             midStart;

	// last cycle of a full bit period
	assign bitEnd = (bitCnt == i_div - DIV_W'(1));

	// half a bit period has passed since the falling edge was seen
	// the compare stays true for tiny dividers so the machine cannot hang
	assign midStart = ((bitCnt + DIV_W'(1)) >= (i_div >> 1));

	//////////////////////////////
	// frame control
	//////////////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			// idle line is high, so the synchronizer starts high too
			rxMeta  <= 1'b1;
			rxSync  <= 1'b1;
			state   <= rxIdle;
			bitCnt  <= '0;
			bitIdx  <= '0;
			o_valid <= 1'b0;
		end else begin
			rxMeta  <= i_rxd;
			rxSync  <= rxMeta;
			// valid is a single-cycle pulse
			o_valid <= 1'b0;
			case (state)
				rxIdle: begin
					bitCnt <= '0;
					bitIdx <= '0;
					// a low level on the synchronized line marks a possible start bit
					if (!rxSync) begin
						state <= rxStart;
					end
				end
				rxStart: begin
					if (midStart) begin
						bitCnt <= '0;
						// line back high at half period is a glitch, not a start bit
						state  <= rxSync ? rxIdle : rxData;
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				rxData: begin
					if (bitEnd) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7) begin
							state <= rxStop;
						end
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				rxStop: begin
					if (bitEnd) begin
						state   <= rxIdle;
						// a low stop bit drops the frame without any report
						o_valid <= rxSync;
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				default: state <= rxIdle;
			endcase
		end
	end

	//////////////////////////////
	// data path
	//////////////////////////////

	always_ff @(posedge CLK) begin
		// data arrives LSB first, so shift in from the top
		if (state == rxData && bitEnd) begin
			shiftReg <= {rxSync, shiftReg[7:1]};
		end
		// the byte is only updated by a good frame and held until the next one
		if (state == rxStop && bitEnd && rxSync) begin
			o_byte <= shiftReg;
		end
	end

endmodule

// ==== design/uartTx.sv ====
`timescale 1ns/1ps

module uartTx #(
	parameter int DIV_W = 16
) (
	input  logic             CLK,
	input  logic             RESET,
	input  logic             i_start,
	input  logic [7:0]       i_byte,
	input  logic [DIV_W-1:0] i_div,
	output logic             o_txd,
	output logic             o_active,
	output logic             o_done
);
	import uartPkg::*;

	txStateE          state;
	logic [DIV_W-1:0] bitCnt;
	logic [2:0]       bitIdx;
	logic [7:0]       shiftReg;
	logic             bitEnd;

	// last cycle of the current bit
	assign bitEnd = (bitCnt == i_div - DIV_W'(1));

	// busy from the first cycle of the start bit to the last cycle of the stop bit
	assign o_active = (state != txIdle);

	// done marks the final cycle of the stop bit
	assign o_done = (state == txStop) && bitEnd;

	//////////////////////////////
	// frame control
	//////////////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state  <= txIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			o_txd  <= 1'b1;
		end else begin
			case (state)
				txIdle: begin
					bitCnt <= '0;
					bitIdx <= '0;
					// start pulses are only looked at here, so they are dropped while busy
					if (i_start) begin
						state <= txStart;
						o_txd <= 1'b0;
					end
				end
				txStart: begin
					if (bitEnd) begin
						bitCnt <= '0;
						state  <= txData;
						o_txd  <= shiftReg[0];
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				txData: begin
					if (bitEnd) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'd7) begin
							// stop bit is a plain high level
							state <= txStop;
							o_txd <= 1'b1;
						end else begin
							o_txd <= shiftReg[0];
						end
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				txStop: begin
					if (bitEnd) begin
						state <= txIdle;
					end else begin
						bitCnt <= bitCnt + DIV_W'(1);
					end
				end
				default: state <= txIdle;
			endcase
		end
	end

	// shift register keeps the next data bit in position 0
	always_ff @(posedge CLK) begin
		if (state == txIdle && i_start) begin
			shiftReg <= i_byte;
		end else if (bitEnd && (state == txStart || state == txData)) begin
			shiftReg <= {1'b0, shiftReg[7:1]};
		end
	end

endmodule

// ==== design/uartRegs.sv ====
`timescale 1ns/1ps

module uartRegs #(
	parameter int DIV_W = 16
) (
	input  logic                       CLK,
	input  logic                       RESET,
	input  logic                       i_pSel,
	input  logic                       i_pEnable,
	input  logic                       i_pWrite,
	input  uartPkg::regAddrE           i_pAddr,
	input  logic [uartPkg::DATA_W-1:0] i_pWData,
	output logic [uartPkg::DATA_W-1:0] o_pRData,
	output logic                       o_txStart,
	output logic [7:0]                 o_txByte,
	output logic [DIV_W-1:0]           o_txDiv,
	input  logic                       i_txActive,
	input  logic                       i_txDone,
	output logic [DIV_W-1:0]           o_rxDiv,
	input  logic                       i_rxValid,
	input  logic [7:0]                 i_rxByte,
	output logic                       o_irq
);
	import uartPkg::*;

	// access cycle of a zero-wait APB transfer
	logic wrAccess;
	logic rdAccess;
	logic dataWrite;
	logic dataRead;

	// latched status flags
	logic rxAvailFlag;
	logic txActiveFlag;
	logic txDoneFlag;

	logic [DATA_W-1:0] statusWord;

	assign wrAccess  = i_pSel && i_pEnable && i_pWrite;
	assign rdAccess  = i_pSel && i_pEnable && !i_pWrite;
	assign dataWrite = wrAccess && (i_pAddr == dataReg);
	assign dataRead  = rdAccess && (i_pAddr == dataReg);

	// interrupt stays up while either completion flag is pending
	assign o_irq = rxAvailFlag || txDoneFlag;

	//////////////////////////////
	// read path
	//////////////////////////////

	always_comb begin
		statusWord                 = '0;
		statusWord[STAT_RX_AVAIL]  = rxAvailFlag;
		statusWord[STAT_TX_ACTIVE] = txActiveFlag;
		statusWord[STAT_TX_DONE]   = txDoneFlag;
	end

	// read data is combinational and only driven while the slave is selected
	always_comb begin
		o_pRData = '0;
		if (i_pSel) begin
			case (i_pAddr)
				statusReg: o_pRData = statusWord;
				dataReg:   o_pRData = {{(DATA_W - 8){1'b0}}, i_rxByte};
				rxDivReg:  o_pRData = DATA_W'(o_rxDiv);
				txDivReg:  o_pRData = DATA_W'(o_txDiv);
				default:   o_pRData = '0;
			endcase
		end
	end

	//////////////////////////////
	// control and status
	//////////////////////////////

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			o_txStart    <= 1'b0;
			o_rxDiv      <= DIV_RESET[DIV_W-1:0];
			o_txDiv      <= DIV_RESET[DIV_W-1:0];
			rxAvailFlag  <= 1'b0;
			txActiveFlag <= 1'b0;
			txDoneFlag   <= 1'b0;
		end else begin
			// start pulse follows the data write by one cycle
			o_txStart <= dataWrite;

			// registered copy, one cycle behind the transmitter
			txActiveFlag <= i_txActive;

			// a new byte wins over a data read in the same cycle
			if (i_rxValid) begin
				rxAvailFlag <= 1'b1;
			end else if (dataRead) begin
				rxAvailFlag <= 1'b0;
			end

			// a data write starts a new frame, so its clear wins over a late done
			if (dataWrite) begin
				txDoneFlag <= 1'b0;
			end else if (i_txDone) begin
				txDoneFlag <= 1'b1;
			end

			// divider writes, status writes fall through and are ignored
			if (wrAccess && i_pAddr == rxDivReg) begin
				o_rxDiv <= i_pWData[DIV_W-1:0];
			end
			if (wrAccess && i_pAddr == txDivReg) begin
				o_txDiv <= i_pWData[DIV_W-1:0];
			end
		end
	end

	// byte to send is captured with the write and held for the transmitter
	always_ff @(posedge CLK) begin
		if (dataWrite) begin
			o_txByte <= i_pWData[7:0];
		end
	end

endmodule

// ==== design/uartTop.sv ====
`timescale 1ns/1ps

module uartTop #(
	parameter int DIV_W = 16
) (
	input  logic                       CLK,
	input  logic                       RESET,
	input  logic                       i_pSel,
	input  logic                       i_pEnable,
	input  logic                       i_pWrite,
	input  uartPkg::regAddrE           i_pAddr,
	input  logic [uartPkg::DATA_W-1:0] i_pWData,
	output logic [uartPkg::DATA_W-1:0] o_pRData,
	input  logic                       i_rxd,
	output logic                       o_txd,
	output logic                       o_irq
);

	// register block to transmitter
	logic             txStart;
	logic [7:0]       txByte;
	logic [DIV_W-1:0] txDiv;
	logic             txActive;
	logic             txDone;

	// register block to receiver
	logic [DIV_W-1:0] rxDiv;
	logic             rxValid;
	logic [7:0]       rxByte;

	// APB slave with dividers and latched status
	uartRegs #(
		.DIV_W(DIV_W)
	) regs_i (
		.CLK        (CLK),
		.RESET      (RESET),
		.i_pSel     (i_pSel),
		.i_pEnable  (i_pEnable),
		.i_pWrite   (i_pWrite),
		.i_pAddr    (i_pAddr),
		.i_pWData   (i_pWData),
		.o_pRData   (o_pRData),
		.o_txStart  (txStart),
		.o_txByte   (txByte),
		.o_txDiv    (txDiv),
		.i_txActive (txActive),
		.i_txDone   (txDone),
		.o_rxDiv    (rxDiv),
		.i_rxValid  (rxValid),
		.i_rxByte   (rxByte),
		.o_irq      (o_irq)
	);

	uartTx #(
		.DIV_W(DIV_W)
	) tx_i (
		.CLK      (CLK),
		.RESET    (RESET),
		.i_start  (txStart),
		.i_byte   (txByte),
		.i_div    (txDiv),
		.o_txd    (o_txd),
		.o_active (txActive),
		.o_done   (txDone)
	);

	uartRx #(
		.DIV_W(DIV_W)
	) rx_i (
		.CLK     (CLK),
		.RESET   (RESET),
		.i_rxd   (i_rxd),
		.i_div   (rxDiv),
		.o_valid (rxValid),
		.o_byte  (rxByte)
	);

endmodule

// ==== bench/uartTb_chk.sv ====
`timescale 1ns/1ps

module uartTbChk (
	input logic                       CLK,
	input logic                       RESET,
	input logic                       i_irq,
	input logic                       i_txStart,
	input logic                       i_rxValid,
	input logic [uartPkg::DATA_W-1:0] i_status
);
	import uartPkg::*;

	// failure counts per property, the testbench adds them into its verdict
	int irqFails;
	int startFails;
	int availFails;
	int assertFails;

	assign assertFails = irqFails + startFails + availFails;

	//////////////////////////////
	// register block properties
	//////////////////////////////

	// the interrupt line is nothing but the two completion flags ORed
	irqIsFlagOr: assert property (@(posedge CLK) disable iff (RESET)
		i_irq == (i_status[STAT_RX_AVAIL] || i_status[STAT_TX_DONE]))
	else begin
		$error("o_irq is not the OR of rx-available and tx-done");
		irqFails++;
	end

	// a data write gives exactly one start pulse
	startIsPulse: assert property (@(posedge CLK) disable iff (RESET)
		i_txStart |=> !i_txStart)
	else begin
		$error("o_txStart stayed high for two cycles");
		startFails++;
	end

	// rx-available is only ever set by a valid pulse from the receiver
	availAfterValid: assert property (@(posedge CLK) disable iff (RESET)
		$rose(i_status[STAT_RX_AVAIL]) |-> $past(i_rxValid))
	else begin
		$error("rx-available rose without a preceding i_rxValid");
		availFails++;
	end

endmodule

bind uartRegs uartTbChk chk_i (
	.CLK       (CLK),
	.RESET     (RESET),
	.i_irq     (o_irq),
	.i_txStart (o_txStart),
	.i_rxValid (i_rxValid),
	.i_status  (statusWord)
);

// ==== bench/uartTb.sv ====
`timescale 1ns/1ps

module uartTb;
	import uartPkg::*;

	localparam int DIV_W      = 16;
	localparam int CLK_PERIOD = 4;
	// largest divider that any frame in the table runs at
	localparam int MAX_DIV    = 16;
	// each status poll costs three clock cycles so this covers a long frame easily
	localparam int POLL_MAX   = 12 * MAX_DIV;
	localparam logic [31:0] RND_SEED = 32'h099cec89;

	localparam logic [DATA_W-1:0] RX_BIT     = DATA_W'(1 << STAT_RX_AVAIL);
	localparam logic [DATA_W-1:0] ACTIVE_BIT = DATA_W'(1 << STAT_TX_ACTIVE);
	localparam logic [DATA_W-1:0] DONE_BIT   = DATA_W'(1 << STAT_TX_DONE);

	// opLoop sends wData and expects it back while opRecv only waits and reads
	typedef enum logic [2:0] {
		opWrite,
		opRead,
		opIrq,
		opLoop,
		opRecv,
		opLoopRand,
		opLoopBad
	} opE;

	typedef struct packed {
		opE                op;
		regAddrE           addr;
		logic [DATA_W-1:0] wData;
		logic [DATA_W-1:0] expVal;
		logic [DATA_W-1:0] mask;
	} stepT;

	logic              CLK;
	logic              RESET;
	logic              pSel;
	logic              pEnable;
	logic              pWrite;
	regAddrE           pAddr;
	logic [DATA_W-1:0] pWData;
	logic [DATA_W-1:0] pRData;
	logic              serialLine;
	logic              irq;

	stepT steps[$];
	int   errCount;
	int   watchdogNs;
	bit   tableLoaded;

	// the transmitter output loops straight back into the receiver
	uartTop #(
		.DIV_W(DIV_W)
	) dut_i (
		.CLK       (CLK),
		.RESET     (RESET),
		.i_pSel    (pSel),
		.i_pEnable (pEnable),
		.i_pWrite  (pWrite),
		.i_pAddr   (pAddr),
		.i_pWData  (pWData),
		.o_pRData  (pRData),
		.i_rxd     (serialLine),
		.o_txd     (serialLine),
		.o_irq     (irq)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	//////////////////////////////
	// APB driver
	//////////////////////////////

	// a setup cycle and an access cycle and then the bus goes back to idle
	task automatic apbWrite(input regAddrE addr, input logic [DATA_W-1:0] data);
		@(posedge CLK);
		pSel    <= 1'b1;
		pEnable <= 1'b0;
		pWrite  <= 1'b1;
		pAddr   <= addr;
		pWData  <= data;
		@(posedge CLK);
		pEnable <= 1'b1;
		@(posedge CLK);
		pSel    <= 1'b0;
		pEnable <= 1'b0;
		pWrite  <= 1'b0;
	endtask

	// read data is taken in the middle of the access cycle well away from any edge
	task automatic apbRead(input regAddrE addr, output logic [DATA_W-1:0] data);
		@(posedge CLK);
		pSel    <= 1'b1;
		pEnable <= 1'b0;
		pWrite  <= 1'b0;
		pAddr   <= addr;
		@(posedge CLK);
		pEnable <= 1'b1;
		@(negedge CLK);
		data = pRData;
		@(posedge CLK);
		pSel    <= 1'b0;
		pEnable <= 1'b0;
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic checkReg(input regAddrE addr, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %s read 16'h%04h, expected 16'h%04h", addr.name(), got, exp);
			errCount++;
		end
	endtask

	task automatic checkIrq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR o_irq is 1'h%0h, expected 1'h%0h", got, exp);
			errCount++;
		end
	endtask

	// reads status until the masked bit is set or the poll budget is used up
	task automatic pollStatus(input logic [DATA_W-1:0] bitMask, output bit seen,
			output logic [DATA_W-1:0] last);
		int polls;
		polls = 0;
		seen  = 1'b0;
		while (!seen && polls < POLL_MAX) begin
			apbRead(statusReg, last);
			seen = ((last & bitMask) != '0);
			polls++;
		end
	endtask

	// waits for the end of the frame and then expects the byte to be there and to match
	task automatic recvCheck(input logic [DATA_W-1:0] expData);
		logic [DATA_W-1:0] rd;
		bit                done;
		pollStatus(DONE_BIT, done, rd);
		if (!done) begin
			$display("the transmission never finished within %0d status polls", POLL_MAX);
			errCount++;
		end else begin
			checkReg(statusReg, rd & RX_BIT, RX_BIT);
			@(negedge CLK);
			checkIrq(irq, 1'b1);
			apbRead(dataReg, rd);
			checkReg(dataReg, rd, expData);
		end
	endtask

	// the receive divider differs from the transmit one so the byte must not survive
	task automatic mismatchCheck(input logic [DATA_W-1:0] sent);
		logic [DATA_W-1:0] rd;
		bit                done;
		bit                avail;
		apbWrite(dataReg, sent);
		pollStatus(DONE_BIT, done, rd);
		if (!done) begin
			$display("the transmission never finished within %0d status polls", POLL_MAX);
			errCount++;
		end else begin
			// the slower receiver is still busy here and gets the whole budget
			pollStatus(RX_BIT, avail, rd);
			if (avail) begin
				apbRead(dataReg, rd);
				if (rd[7:0] == sent[7:0]) begin
					$display("the byte came back intact although the dividers differ");
					errCount++;
				end
			end
		end
	endtask

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	task automatic addStep(input opE op, input regAddrE addr, input logic [DATA_W-1:0] wData,
			input logic [DATA_W-1:0] expVal, input logic [DATA_W-1:0] mask);
		steps.push_back(stepT'{op, addr, wData, expVal, mask});
	endtask

	task automatic buildTable();
		// values straight out of reset
		addStep(opRead, statusReg, 16'h0000, 16'h0000, 16'hFFFF);
		addStep(opRead, rxDivReg, 16'h0000, DIV_RESET, 16'hFFFF);
		addStep(opRead, txDivReg, 16'h0000, DIV_RESET, 16'hFFFF);
		addStep(opIrq, statusReg, 16'h0000, 16'h0000, 16'h0001);
		// divider readback and a status write that must be dropped
		addStep(opWrite, rxDivReg, 16'd8, 16'h0000, 16'h0000);
		addStep(opWrite, txDivReg, 16'd8, 16'h0000, 16'h0000);
		addStep(opRead, rxDivReg, 16'h0000, 16'd8, 16'hFFFF);
		addStep(opRead, txDivReg, 16'h0000, 16'd8, 16'hFFFF);
		addStep(opWrite, statusReg, 16'hFFFF, 16'h0000, 16'h0000);
		addStep(opRead, statusReg, 16'h0000, 16'h0000, 16'hFFFF);
		// first loopback frame
		addStep(opLoop, dataReg, 16'h00A5, 16'h00A5, 16'hFFFF);
		// the data read cleared rx-available while tx-done is still pending
		addStep(opRead, statusReg, 16'h0000, DONE_BIT, 16'hFFFF);
		addStep(opWrite, dataReg, 16'h005A, 16'h0000, 16'h0000);
		// both flags are clear right after the write
		addStep(opIrq, statusReg, 16'h0000, 16'h0000, 16'h0001);
		// the new frame has started and the registered busy copy has caught up
		addStep(opRead, statusReg, 16'h0000, ACTIVE_BIT, 16'hFFFF);
		addStep(opRecv, dataReg, 16'h0000, 16'h005A, 16'hFFFF);
		// tx-done alone keeps the interrupt up
		addStep(opIrq, statusReg, 16'h0000, 16'h0001, 16'h0001);
		repeat (6) begin
			addStep(opLoopRand, dataReg, 16'h0000, 16'h0000, 16'hFFFF);
		end
		// receiver runs at half the transmit rate
		addStep(opWrite, rxDivReg, 16'd16, 16'h0000, 16'h0000);
		addStep(opLoopBad, dataReg, 16'h003C, 16'h0000, 16'h0000);
		addStep(opWrite, rxDivReg, 16'd8, 16'h0000, 16'h0000);
		addStep(opLoop, dataReg, 16'h00C3, 16'h00C3, 16'hFFFF);
	endtask

	task automatic runStep(input int idx, input stepT st);
		opE                op;
		regAddrE           addr;
		logic [DATA_W-1:0] rd;
		logic [7:0]        rndByte;
		int                errBefore;
		op        = st.op;
		addr      = st.addr;
		errBefore = errCount;
		case (op)
			opWrite: apbWrite(addr, st.wData);
			opRead: begin
				apbRead(addr, rd);
				checkReg(addr, rd & st.mask, st.expVal & st.mask);
			end
			opIrq: begin
				@(negedge CLK);
				checkIrq(irq, st.expVal[0]);
			end
			opLoop: begin
				apbWrite(dataReg, st.wData);
				recvCheck(st.expVal);
			end
			opRecv: recvCheck(st.expVal);
			opLoopRand: begin
				rndByte = 8'($urandom());
				apbWrite(dataReg, {8'h00, rndByte});
				recvCheck({8'h00, rndByte});
			end
			opLoopBad: mismatchCheck(st.wData);
			default: begin
				$display("row %0d holds an unknown operation", idx);
				errCount++;
			end
		endcase
		$display("row %0d %s %s %s", idx, op.name(), addr.name(),
			(errCount == errBefore) ? "ok" : "FAILED");
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int rowsPassed;
		int rowsFailed;
		int errBefore;
		int chkFails;
		RESET   <= 1'b1;
		pSel    <= 1'b0;
		pEnable <= 1'b0;
		pWrite  <= 1'b0;
		pAddr   <= statusReg;
		pWData  <= '0;
		errCount   = 0;
		rowsPassed = 0;
		rowsFailed = 0;
		void'($urandom(RND_SEED));
		buildTable();
		// every row is granted twelve bit times at the slowest divider and that twice over
		watchdogNs  = steps.size() * 12 * MAX_DIV * CLK_PERIOD * 2;
		tableLoaded = 1'b1;
		repeat (3) @(posedge CLK);
		RESET <= 1'b0;
		foreach (steps[i]) begin
			errBefore = errCount;
			runStep(i, steps[i]);
			if (errCount == errBefore) begin
				rowsPassed++;
			end else begin
				rowsFailed++;
			end
		end
		chkFails = dut_i.regs_i.chk_i.assertFails;
		$display("rows passed %0d, rows failed %0d, assertion failures %0d",
			rowsPassed, rowsFailed, chkFails);
		if (errCount == 0 && chkFails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// ends a run that stops making progress
	initial begin
		wait (tableLoaded);
		#(watchdogNs);
		$display("watchdog expired after %0d ns before all rows had run", watchdogNs);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== flist.f ====
design/uartPkg.sv
design/uartRx.sv
design/uartTx.sv
design/uartRegs.sv
design/uartTop.sv
bench/uartTb_chk.sv
bench/uartTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the UART testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=uartTbSim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module uartTb -f flist.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1
